// ==== hdl/cq_sched_pkg.sv ====
// CQ scheduling package
// Shared counts, widths, select limits, register addresses and types for the
// consumer-queue write path
package cq_sched_pkg;

  // ------------------------------------------------------------
  // sizes and limits
  // ------------------------------------------------------------
  localparam int NUM_CQ       = 4;
  localparam int CQ_ID_W      = 2;
  localparam int LINE_ENTRIES = 4;

  // largest token depth select that each family supports
  localparam int LDB_MAX_SEL = 8;
  localparam int DIR_MAX_SEL = 10;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  localparam int ADDR_LDB_PAD  = 0;
  localparam int ADDR_DIR_PAD  = 1;
  localparam int ADDR_LDB_SEL0 = 2;
  localparam int ADDR_DIR_SEL0 = 6;

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  typedef logic [CQ_ID_W-1:0] cq_id_t;
  typedef logic [1:0]         wptr_t;
  typedef logic [3:0]         depth_sel_t;
  typedef logic [10:0]        ldb_depth_t;
  typedef logic [12:0]        dir_depth_t;
  typedef logic [3:0]         tok_cnt_t;
  typedef logic [3:0]         cfg_addr_t;
  typedef logic [7:0]         cfg_data_t;

endpackage

// ==== hdl/cq_cfg_regs.sv ====
// CQ configuration registers
// Holds the per-family pad enables and the per-CQ token depth selects,
// written by strobe and read back combinationally
`timescale 1ns/10ps

module cq_cfg_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cfg_we,
  input  cq_sched_pkg::cfg_addr_t cfg_addr,
  input  cq_sched_pkg::cfg_data_t cfg_wdata,
  output cq_sched_pkg::cfg_data_t cfg_rdata,
  output logic                    cfg_pad_write_ldb,
  output logic                    cfg_pad_first_write_ldb,
  output logic                    cfg_pad_write_dir,
  output logic                    cfg_pad_first_write_dir,
  output cq_sched_pkg::depth_sel_t ldb_depth_sel [cq_sched_pkg::NUM_CQ],
  output cq_sched_pkg::depth_sel_t dir_depth_sel [cq_sched_pkg::NUM_CQ]
);

  import cq_sched_pkg::*;

  // ------------------------------------------------------------
  // register writes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_pad_write_ldb       <= 1'b0;
      cfg_pad_first_write_ldb <= 1'b0;
      cfg_pad_write_dir       <= 1'b0;
      cfg_pad_first_write_dir <= 1'b0;
      for (int i = 0; i < NUM_CQ; i++) begin
        ldb_depth_sel[i] <= '0;
        dir_depth_sel[i] <= '0;
      end
    end else if (cfg_we) begin
      // pad bits share one layout, bit 0 pad-write and bit 1 pad-first-write
      if (cfg_addr == cfg_addr_t'(ADDR_LDB_PAD)) begin
        cfg_pad_write_ldb       <= cfg_wdata[0];
        cfg_pad_first_write_ldb <= cfg_wdata[1];
      end
      if (cfg_addr == cfg_addr_t'(ADDR_DIR_PAD)) begin
        cfg_pad_write_dir       <= cfg_wdata[0];
        cfg_pad_first_write_dir <= cfg_wdata[1];
      end
      // out-of-range selects are stored as written and rejected by the pad logic
      for (int i = 0; i < NUM_CQ; i++) begin
        if (cfg_addr == cfg_addr_t'(ADDR_LDB_SEL0 + i)) begin
          ldb_depth_sel[i] <= cfg_wdata[3:0];
        end
        if (cfg_addr == cfg_addr_t'(ADDR_DIR_SEL0 + i)) begin
          dir_depth_sel[i] <= cfg_wdata[3:0];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // read mux, unmapped addresses return zero
  // ------------------------------------------------------------
  always_comb begin
    cfg_rdata = '0;
    if (cfg_addr == cfg_addr_t'(ADDR_LDB_PAD)) begin
      cfg_rdata = {6'b0, cfg_pad_first_write_ldb, cfg_pad_write_ldb};
    end
    if (cfg_addr == cfg_addr_t'(ADDR_DIR_PAD)) begin
      cfg_rdata = {6'b0, cfg_pad_first_write_dir, cfg_pad_write_dir};
    end
    for (int i = 0; i < NUM_CQ; i++) begin
      if (cfg_addr == cfg_addr_t'(ADDR_LDB_SEL0 + i)) begin
        cfg_rdata = cfg_data_t'(ldb_depth_sel[i]);
      end
      if (cfg_addr == cfg_addr_t'(ADDR_DIR_SEL0 + i)) begin
        cfg_rdata = cfg_data_t'(dir_depth_sel[i]);
      end
    end
  end

  // a write with an undefined address could land in any register
  a_cfg_addr_known : assert property (
    @(posedge clk) disable iff (reset) cfg_we |-> !$isunknown(cfg_addr)
  ) else $error("cfg write with unknown address");

endmodule

// ==== hdl/cq_occupancy.sv ====
// CQ occupancy tracker
// Keeps the depth and the write pointer within the four-entry line for each CQ
// of one family, the depth width set by a type parameter
`timescale 1ns/10ps

module cq_occupancy #(
  parameter type depth_t = cq_sched_pkg::ldb_depth_t
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sched_req,
  input  cq_sched_pkg::cq_id_t   sched_cq,
  input  logic                   tok_valid,
  input  cq_sched_pkg::cq_id_t   tok_cq,
  input  cq_sched_pkg::tok_cnt_t tok_cnt,
  output depth_t                 cur_depth,
  output cq_sched_pkg::wptr_t    cur_wptr
);

  import cq_sched_pkg::*;

  depth_t depth_q [NUM_CQ];
  wptr_t  wptr_q  [NUM_CQ];

  // per-CQ increment and decrement for this cycle
  logic   inc     [NUM_CQ];
  depth_t dec     [NUM_CQ];

  // ------------------------------------------------------------
  // decode the strobes per CQ
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_CQ; i++) begin
      inc[i] = sched_req && (sched_cq == cq_id_t'(i));
      dec[i] = '0;
      if (tok_valid && (tok_cq == cq_id_t'(i))) begin
        dec[i] = depth_t'(tok_cnt);
      end
    end
  end

  // ------------------------------------------------------------
  // depth and write pointer state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CQ; i++) begin
        depth_q[i] <= '0;
        wptr_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CQ; i++) begin
        // a schedule and a token return to the same CQ both land in this edge
        depth_q[i] <= depth_q[i] + depth_t'(inc[i]) - dec[i];
        if (inc[i]) begin
          // wraps at the end of the line
          wptr_q[i] <= wptr_q[i] + 2'd1;
        end
      end
    end
  end

  // the scheduled CQ's state as it stands before this write
  assign cur_depth = depth_q[sched_cq];
  assign cur_wptr  = wptr_q[sched_cq];

  // tokens come back only for entries that were written, counting a write
  // to the same CQ in this cycle
  a_tok_underflow : assert property (
    @(posedge clk) disable iff (reset)
    tok_valid |-> int'(tok_cnt) <=
      int'(depth_q[tok_cq]) + int'(sched_req && (sched_cq == tok_cq))
  ) else $error("token return exceeds depth of cq %0d", tok_cq);

endmodule

// ==== hdl/wb_pad_flag.sv ====
// Write buffer pad flag
// Decides whether the write to the scheduled CQ may pad out the rest of the
// cache line, from the depth, write pointer and token depth select
`timescale 1ns/10ps

module wb_pad_flag (
  input  logic                     is_ldb,
  input  logic                     cfg_pad_write_ldb,
  input  logic                     cfg_pad_first_write_ldb,
  input  logic                     cfg_pad_write_dir,
  input  logic                     cfg_pad_first_write_dir,
  input  cq_sched_pkg::wptr_t      ldb_cq_wptr,
  input  cq_sched_pkg::wptr_t      dir_cq_wptr,
  input  cq_sched_pkg::depth_sel_t ldb_depth_sel,
  input  cq_sched_pkg::depth_sel_t dir_depth_sel,
  input  cq_sched_pkg::ldb_depth_t ldb_cq_depth,
  input  cq_sched_pkg::dir_depth_t dir_cq_depth,
  output logic                     pad_ok
);

  import cq_sched_pkg::*;

  logic ldb_pad_ok;
  logic dir_pad_ok;

  // ------------------------------------------------------------
  // pad rule for one family
  // ------------------------------------------------------------
  // capacity is four entries shifted left by the select, and the padded line
  // must still fit, so the threshold grows by the entries already in the line
  function automatic logic pad_rule(
    input int unsigned depth,
    input depth_sel_t  sel,
    input wptr_t       wptr,
    input logic        first_write_only,
    input int unsigned max_sel
  );
    int unsigned cap;
    int unsigned limit;
    cap   = LINE_ENTRIES << sel;
    limit = cap - LINE_ENTRIES + wptr;
    if (sel > max_sel) begin
      return 1'b0;
    end
    if (wptr == '0) begin
      return depth <= limit;
    end
    // mid-line writes pad only when padding is not restricted to the first write
    return (depth <= limit) && !first_write_only;
  endfunction

  always_comb begin
    ldb_pad_ok = pad_rule(int'(ldb_cq_depth), ldb_depth_sel, ldb_cq_wptr,
                          cfg_pad_first_write_ldb, LDB_MAX_SEL);
    dir_pad_ok = pad_rule(int'(dir_cq_depth), dir_depth_sel, dir_cq_wptr,
                          cfg_pad_first_write_dir, DIR_MAX_SEL);
  end

  // either enable bit turns padding on for its family
  assign pad_ok = is_ldb ?
                  ((cfg_pad_write_ldb | cfg_pad_first_write_ldb) & ldb_pad_ok) :
                  ((cfg_pad_write_dir | cfg_pad_first_write_dir) & dir_pad_ok);

endmodule

// ==== hdl/cq_sched_out.sv ====
// Schedule output stage
// Registers each scheduled write together with its pad decision, one cycle
// after the schedule strobe
`timescale 1ns/10ps

module cq_sched_out (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sched_req,
  input  logic                 sched_is_ldb,
  input  cq_sched_pkg::cq_id_t sched_cq,
  input  logic                 pad_ok,
  output logic                 out_valid,
  output logic                 out_is_ldb,
  output cq_sched_pkg::cq_id_t out_cq,
  output logic                 out_pad
);

  import cq_sched_pkg::*;

  // ------------------------------------------------------------
  // control bits
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_pad   <= 1'b0;
    end else begin
      out_valid <= sched_req;
      // the pad flag only means something alongside a valid write
      out_pad   <= sched_req & pad_ok;
    end
  end

  // ------------------------------------------------------------
  // write identity captured with each schedule
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sched_req) begin
      out_is_ldb <= sched_is_ldb;
      out_cq     <= cq_id_t'(sched_cq);
    end
  end

  // the flag must never appear on a cycle without a write
  a_pad_needs_valid : assert property (
    @(posedge clk) disable iff (reset) $rose(out_pad) |-> out_valid
  ) else $error("out_pad rose without out_valid");

endmodule

// ==== hdl/cq_sched_top.sv ====
// CQ scheduling write path
// Connects the config registers, the two occupancy trackers, the pad flag and
// the output stage
`timescale 1ns/10ps

module cq_sched_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cfg_we,
  input  cq_sched_pkg::cfg_addr_t  cfg_addr,
  input  cq_sched_pkg::cfg_data_t  cfg_wdata,
  input  logic                     sched_req,
  input  logic                     sched_is_ldb,
  input  cq_sched_pkg::cq_id_t     sched_cq,
  input  logic                     tok_valid,
  input  logic                     tok_is_ldb,
  input  cq_sched_pkg::cq_id_t     tok_cq,
  input  cq_sched_pkg::tok_cnt_t   tok_cnt,
  output cq_sched_pkg::cfg_data_t  cfg_rdata,
  output logic                     out_valid,
  output logic                     out_is_ldb,
  output cq_sched_pkg::cq_id_t     out_cq,
  output logic                     out_pad
);

  import cq_sched_pkg::*;

  logic       cfg_pad_write_ldb;
  logic       cfg_pad_first_write_ldb;
  logic       cfg_pad_write_dir;
  logic       cfg_pad_first_write_dir;
  depth_sel_t ldb_depth_sel [NUM_CQ];
  depth_sel_t dir_depth_sel [NUM_CQ];
  ldb_depth_t ldb_cq_depth;
  dir_depth_t dir_cq_depth;
  wptr_t      ldb_cq_wptr;
  wptr_t      dir_cq_wptr;
  logic       pad_ok;

  cq_cfg_regs u_cfg (
    .clk, .reset, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .cfg_pad_write_ldb, .cfg_pad_first_write_ldb,
    .cfg_pad_write_dir, .cfg_pad_first_write_dir,
    .ldb_depth_sel, .dir_depth_sel
  );

  // ------------------------------------------------------------
  // one tracker per family, strobes qualified by family
  // ------------------------------------------------------------
  cq_occupancy #(.depth_t(ldb_depth_t)) u_ldb_occ (
    .clk, .reset,
    .sched_req (sched_req & sched_is_ldb),
    .sched_cq,
    .tok_valid (tok_valid & tok_is_ldb),
    .tok_cq, .tok_cnt,
    .cur_depth (ldb_cq_depth),
    .cur_wptr  (ldb_cq_wptr)
  );

  cq_occupancy #(.depth_t(dir_depth_t)) u_dir_occ (
    .clk, .reset,
    .sched_req (sched_req & ~sched_is_ldb),
    .sched_cq,
    .tok_valid (tok_valid & ~tok_is_ldb),
    .tok_cq, .tok_cnt,
    .cur_depth (dir_cq_depth),
    .cur_wptr  (dir_cq_wptr)
  );

  // the select of the scheduled CQ in each family
  wb_pad_flag u_pad (
    .is_ldb (sched_is_ldb),
    .cfg_pad_write_ldb, .cfg_pad_first_write_ldb,
    .cfg_pad_write_dir, .cfg_pad_first_write_dir,
    .ldb_cq_wptr, .dir_cq_wptr,
    .ldb_depth_sel (ldb_depth_sel[sched_cq]),
    .dir_depth_sel (dir_depth_sel[sched_cq]),
    .ldb_cq_depth, .dir_cq_depth,
    .pad_ok
  );

  cq_sched_out u_out (
    .clk, .reset, .sched_req, .sched_is_ldb, .sched_cq, .pad_ok,
    .out_valid, .out_is_ldb, .out_cq, .out_pad
  );

endmodule

// ==== tests/cq_sched_tb.sv ====
// CQ scheduling testbench
// Replays config, schedule and token operations from the stimulus file and
// checks read data and the registered schedule outputs of the write path
`timescale 1ns/10ps

module cq_sched_tb;

  import cq_sched_pkg::*;

  localparam int    MAX_OPS   = 64;
  localparam string STIM_FILE = "tests/cq_sched_stim.txt";

  logic       clk;
  logic       reset;
  logic       cfg_we;
  cfg_addr_t  cfg_addr;
  cfg_data_t  cfg_wdata;
  cfg_data_t  cfg_rdata;
  logic       sched_req;
  logic       sched_is_ldb;
  cq_id_t     sched_cq;
  logic       tok_valid;
  logic       tok_is_ldb;
  cq_id_t     tok_cq;
  tok_cnt_t   tok_cnt;
  logic       out_valid;
  logic       out_is_ldb;
  cq_id_t     out_cq;
  logic       out_pad;

  logic [31:0] stim [MAX_OPS];
  // model state, family 0 is ldb and family 1 is dir
  int   model_depth [2][NUM_CQ];
  int   model_wptr  [2][NUM_CQ];
  int   model_sel   [2][NUM_CQ];
  logic model_pw    [2];
  logic model_pfw   [2];
  int   mismatches = 0;
  int   failures   = 0;
  int   cycles     = 0;
  int   limit      = 0;
  int   seed       = 32'h474d;

  cq_sched_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, stimulus did not complete", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // model of the pad rule, used to cross-check the file
  // ------------------------------------------------------------
  function automatic logic rule_pad(input logic is_ldb, input cq_id_t cq);
    int f;
    int max_sel;
    int thresh;
    f       = is_ldb ? 0 : 1;
    max_sel = is_ldb ? LDB_MAX_SEL : DIR_MAX_SEL;
    if (!(model_pw[f] || model_pfw[f]) || model_sel[f][cq] > max_sel) begin
      return 1'b0;
    end
    thresh = (4 << model_sel[f][cq]) - 4 + model_wptr[f][cq];
    if (model_depth[f][cq] > thresh) begin
      return 1'b0;
    end
    return (model_wptr[f][cq] == 0) || !model_pfw[f];
  endfunction

  task automatic model_cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    int a;
    a = int'(addr);
    if (a <= 1) begin
      model_pw[a]  = data[0];
      model_pfw[a] = data[1];
    end else if (a <= 5) begin
      model_sel[0][a-2] = int'(data[3:0]);
    end else if (a <= 9) begin
      model_sel[1][a-6] = int'(data[3:0]);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_rdata(input cfg_addr_t addr, input cfg_data_t exp, input cfg_data_t got);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch cfg_rdata at addr %h: expected %h, got %h", addr, exp, got);
    end
  endtask

  task automatic check_sched(input logic exp_pad, input logic exp_is_ldb, input cq_id_t exp_cq);
    if (out_valid !== 1'b1) begin
      failures++;
      $display("out_valid stayed low in the cycle after the schedule to cq %0d", exp_cq);
    end else begin
      if (out_is_ldb !== exp_is_ldb) begin
        mismatches++;
        $display("mismatch out_is_ldb: expected %h, got %h", exp_is_ldb, out_is_ldb);
      end
      if (out_cq !== exp_cq) begin
        mismatches++;
        $display("mismatch out_cq: expected %h, got %h", exp_cq, out_cq);
      end
      if (out_pad !== exp_pad) begin
        mismatches++;
        $display("mismatch out_pad for cq %0d: expected %h, got %h", exp_cq, exp_pad, out_pad);
      end
    end
  endtask

  // one schedule, optionally with a token return to the same CQ in that cycle
  task automatic run_sched(input logic is_ldb, input cq_id_t cq, input logic exp_pad,
                           input logic with_tok, input tok_cnt_t cnt);
    int f;
    f = is_ldb ? 0 : 1;
    if (rule_pad(is_ldb, cq) !== exp_pad) begin
      failures++;
      $display("stimulus expects pad %0d for cq %0d, which breaks the pad rule", exp_pad, cq);
    end
    sched_req    = 1'b1;
    sched_is_ldb = is_ldb;
    sched_cq     = cq;
    tok_valid    = with_tok;
    tok_is_ldb   = is_ldb;
    tok_cq       = cq;
    tok_cnt      = cnt;
    model_depth[f][cq] += 1 - (with_tok ? int'(cnt) : 0);
    model_wptr[f][cq]   = (model_wptr[f][cq] + 1) % 4;
    next_cycle();
    sched_req = 1'b0;
    tok_valid = 1'b0;
    check_sched(exp_pad, is_ldb, cq);
  endtask

  // ------------------------------------------------------------
  // stimulus replay
  // ------------------------------------------------------------
  initial begin
    logic [31:0] op;
    int          n_ops;
    int          gap;
    reset        = 1'b1;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    sched_req    = 1'b0;
    sched_is_ldb = 1'b0;
    sched_cq     = '0;
    tok_valid    = 1'b0;
    tok_is_ldb   = 1'b0;
    tok_cq       = '0;
    tok_cnt      = '0;
    for (int f = 0; f < 2; f++) begin
      model_pw[f]  = 1'b0;
      model_pfw[f] = 1'b0;
      for (int c = 0; c < NUM_CQ; c++) begin
        model_depth[f][c] = 0;
        model_wptr[f][c]  = 0;
        model_sel[f][c]   = 0;
      end
    end
    $readmemh(STIM_FILE, stim);
    n_ops = 0;
    for (int i = 0; i < MAX_OPS && stim[i][31:28] != 4'hF; i++) begin
      n_ops += (stim[i][31:28] == 4'h3) ? int'(stim[i][11:0]) : 1;
    end
    limit = 4 * n_ops + 20;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    if (out_valid !== 1'b0) begin
      failures++;
      $display("out_valid is not low after reset");
    end

    for (int i = 0; i < MAX_OPS && stim[i][31:28] != 4'hF; i++) begin
      op  = stim[i];
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) next_cycle();
      case (op[31:28])
        4'h1: begin
          cfg_we    = 1'b1;
          cfg_addr  = op[23:20];
          cfg_wdata = op[7:0];
          model_cfg_write(op[23:20], op[7:0]);
          next_cycle();
          cfg_we = 1'b0;
        end
        4'h2: begin
          cfg_addr = op[23:20];
          next_cycle();
          check_rdata(op[23:20], op[7:0], cfg_rdata);
        end
        4'h3: repeat (op[11:0]) run_sched(op[24], op[21:20], op[12], 1'b0, '0);
        4'h4: begin
          tok_valid  = 1'b1;
          tok_is_ldb = op[24];
          tok_cq     = op[21:20];
          tok_cnt    = op[19:16];
          model_depth[op[24] ? 0 : 1][op[21:20]] -= int'(op[19:16]);
          next_cycle();
          tok_valid = 1'b0;
        end
        4'h5: run_sched(op[24], op[21:20], op[12], 1'b1, op[19:16]);
        default: begin
          failures++;
          $display("unknown operation code %h in stimulus line %0d", op[31:28], i);
        end
      endcase
    end

    next_cycle();
    $display("%0d mismatches, %0d other failures, %0d cycles", mismatches, failures, cycles);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/cq_sched_stim.txt ====
// columns: op[31:28] is_ldb[27:24] cq_or_addr[23:20] tok_cnt[19:16] exp_pad[15:12] data[11:0]
// op 1 cfg write, 2 cfg read and compare, 3 schedule data times, 4 token return,
// op 5 schedule with token return to the same CQ, F end of stimulus
20000000 // registers read zero after reset
20100000
20900000
30300001 // pad bits clear, no padding
10200009 // ldb cq0 select above the ldb maximum
20200009
20300000
1070000A // dir cq1 select 10
2070000A
20600000
10C000FF // unmapped address ignores the write
20C00000
10000001 // ldb pad-write
20000001
31000001 // select 9 on ldb disallows padding
31101004 // ldb cq1 select 0 across pointers 0 to 3
31100001
41140000
31101001
10000002 // ldb pad-first-write
41120000
31100002
41120000
31101001
10100002 // dir pad-first-write
30201001
30200001
10600009 // dir cq0 select 9
10100000 // fill dir cq0 and cq1 with padding off
300007FC
30100800
10100001 // dir pad-write
30001001
30001003
30000001
30101001
10000001 // ldb pad-write again
31201004
51240000 // schedule and token return in one cycle
31201001
F0000000

// ==== flist.f ====
hdl/cq_sched_pkg.sv
hdl/cq_cfg_regs.sv
hdl/cq_occupancy.sv
hdl/wb_pad_flag.sv
hdl/cq_sched_out.sv
hdl/cq_sched_top.sv
tests/cq_sched_tb.sv

// ==== Bender.yml ====
package:
  name: cq_sched

sources:
  - hdl/cq_sched_pkg.sv
  - hdl/cq_cfg_regs.sv
  - hdl/cq_occupancy.sv
  - hdl/wb_pad_flag.sv
  - hdl/cq_sched_out.sv
  - hdl/cq_sched_top.sv
  - target: test
    files:
      - tests/cq_sched_tb.sv
